// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_effect_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

// File: design/anim_ctrl.sv
/*
    animation control with the scan prescaler, digit scan counter and frame timer.
    the frame advances every frame_ticks scan ticks while run is high.
*/

`timescale 1ns/1ps

module anim_ctrl #(
    parameter int tick_div = 25000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  effect_pkg::rate_t   rate,
    output effect_pkg::digit_t  digit,
    output effect_pkg::frame_t  frame
);

    effect_pkg::presc_t presc;
    logic [5:0]         tick_cnt;
    logic               scan_tick;

    assign scan_tick = (presc == effect_pkg::presc_t'(tick_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (scan_tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // digit scan runs whether or not the animation does.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= '0;
        end else if (scan_tick) begin
            if (digit == effect_pkg::digit_t'(effect_pkg::num_digits - 1)) begin
                digit <= '0;
            end else begin
                digit <= digit + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            frame    <= '0;
        end else if (!run) begin
            tick_cnt <= '0;
            frame    <= '0;
        end else if (scan_tick) begin
            if (tick_cnt >= effect_pkg::frame_ticks[rate] - 6'd1) begin
                tick_cnt <= '0;
                if (frame == effect_pkg::last_frame) begin
                    frame <= '0;
                end else begin
                    frame <= frame + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/display_driver.sv
/*
    display driver that turns the digit kind into a segment pattern and
    registers it together with the active-low digit select.
*/

`timescale 1ns/1ps

module display_driver (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  effect_pkg::kind_t                    kind,
    input  effect_pkg::seg_t                     glyph,
    input  effect_pkg::digit_t                   digit,
    output logic [$bits(effect_pkg::seg_t)-1:0]  digit_sel,
    output effect_pkg::seg_t                     segments
);

    effect_pkg::seg_t pattern;
    logic [$bits(effect_pkg::seg_t)-1:0] sel_next;

    always_comb begin
        case (kind)
            effect_pkg::kind_ball:  pattern = effect_pkg::seg_ball;
            effect_pkg::kind_dash:  pattern = effect_pkg::seg_dash;
            effect_pkg::kind_hook:  pattern = effect_pkg::seg_hook;
            effect_pkg::kind_floor: pattern = effect_pkg::seg_floor;
            effect_pkg::kind_text:  pattern = glyph;
            default:                pattern = effect_pkg::seg_blank;
        endcase
    end

    // position 0 sits on the top select bit.
    assign sel_next = ~(7'b1000000 >> digit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= '1;
            segments  <= effect_pkg::seg_blank;
        end else begin
            digit_sel <= sel_next;
            segments  <= pattern;
        end
    end

endmodule

// File: design/effect_pkg.sv
/*
    shared types and constants for the seven-digit ball, hook and erase animation.
    segment patterns are active low with bit 6 driving segment g.
*/

package effect_pkg;

    localparam int num_digits = 7;
    localparam int presc_w = 16;

    typedef logic [2:0] digit_t;
    typedef logic [5:0] frame_t;
    typedef logic [6:0] seg_t;
    typedef logic [6:0] code_t;
    typedef logic [1:0] rate_t;
    typedef logic [presc_w-1:0] presc_t;

    typedef enum logic [2:0] {
        kind_blank,
        kind_ball,
        kind_dash,
        kind_hook,
        kind_floor,
        kind_text
    } kind_t;

    localparam seg_t seg_blank = 7'b1111111;
    localparam seg_t seg_ball  = 7'b0111000;
    localparam seg_t seg_dash  = 7'b0111111;
    localparam seg_t seg_hook  = 7'b1001100;
    localparam seg_t seg_floor = 7'b1111101;

    // hex digits 0 to F.
    localparam seg_t glyph_table [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    // frame landmarks of the animation.
    localparam frame_t frame_ball_last   = 6'd7;
    localparam frame_t frame_first_char  = 6'd8;
    localparam frame_t frame_hook_last   = 6'd14;
    localparam frame_t frame_all_dash    = 6'd15;
    localparam frame_t frame_pull_last   = 6'd21;
    localparam frame_t frame_blink_first = 6'd22;
    localparam frame_t frame_blink_off   = 6'd23;
    localparam frame_t frame_blink_last  = 6'd25;
    localparam frame_t frame_erase_last  = 6'd32;
    localparam frame_t last_frame        = 6'd33;

    // scan ticks per frame for each rate.
    localparam logic [5:0] frame_ticks [4] = '{6'd56, 6'd28, 6'd14, 6'd7};

endpackage

// File: design/effect_top.sv
/*
    top level of the seven-digit animation display.
    connects timing, text store, frame composer and output driver.
*/

`timescale 1ns/1ps

module effect_top #(
    parameter int tick_div = 25000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  effect_pkg::rate_t   rate,
    input  logic                wr_en,
    input  effect_pkg::digit_t  wr_slot,
    input  effect_pkg::code_t   wr_code,
    output logic [6:0]          digit_sel,
    output effect_pkg::seg_t    segments
);

    effect_pkg::digit_t digit;
    effect_pkg::frame_t frame;
    effect_pkg::kind_t  kind;
    effect_pkg::digit_t slot;
    effect_pkg::seg_t   glyph;

    anim_ctrl #(
        .tick_div (tick_div)
    ) anim_ctrl_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .rate  (rate),
        .digit (digit),
        .frame (frame)
    );

    text_store text_store_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_slot (wr_slot),
        .wr_code (wr_code),
        .slot    (slot),
        .glyph   (glyph)
    );

    frame_composer frame_composer_inst (
        .frame (frame),
        .digit (digit),
        .kind  (kind),
        .slot  (slot)
    );

    display_driver display_driver_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .kind      (kind),
        .glyph     (glyph),
        .digit     (digit),
        .digit_sel (digit_sel),
        .segments  (segments)
    );

endmodule

// File: design/frame_composer.sv
/*
    frame composer that picks what each digit shows for the current frame.
    gives a fixed pattern kind, or text with the slot to read.
*/

`timescale 1ns/1ps

module frame_composer (
    input  effect_pkg::frame_t  frame,
    input  effect_pkg::digit_t  digit,
    output effect_pkg::kind_t   kind,
    output effect_pkg::digit_t  slot
);

    effect_pkg::frame_t pos;
    effect_pkg::frame_t ball_pos;
    effect_pkg::frame_t hook_out;
    effect_pkg::frame_t hook_back;
    effect_pkg::frame_t dash_pos;

    assign pos = {3'b000, digit};

    // marker positions are only meaningful inside their own frame range.
    assign ball_pos  = effect_pkg::frame_ball_last - frame;
    assign hook_out  = frame - effect_pkg::frame_first_char;
    assign hook_back = effect_pkg::frame_blink_first - frame;
    assign dash_pos  = effect_pkg::frame_erase_last - frame;

    always_comb begin
        kind = effect_pkg::kind_blank;
        slot = digit;
        if (frame == '0 || frame == effect_pkg::last_frame) begin
            kind = effect_pkg::kind_floor;
        end else if (frame <= effect_pkg::frame_ball_last) begin
            if (pos < ball_pos) begin
                kind = effect_pkg::kind_floor;
            end else if (pos == ball_pos) begin
                kind = effect_pkg::kind_ball;
            end
        end else if (digit == '0 && frame <= effect_pkg::frame_pull_last) begin
            // the first character stays put through the hook frames.
            kind = effect_pkg::kind_text;
            slot = '0;
        end else if (frame == effect_pkg::frame_first_char) begin
            kind = effect_pkg::kind_blank;
        end else if (frame <= effect_pkg::frame_hook_last) begin
            if (pos < hook_out) begin
                kind = effect_pkg::kind_dash;
            end else if (pos == hook_out) begin
                kind = effect_pkg::kind_hook;
            end
        end else if (frame == effect_pkg::frame_all_dash) begin
            kind = effect_pkg::kind_dash;
        end else if (frame <= effect_pkg::frame_pull_last) begin
            if (pos < hook_back) begin
                kind = effect_pkg::kind_dash;
            end else if (pos == hook_back) begin
                kind = effect_pkg::kind_hook;
            end else begin
                kind = effect_pkg::kind_text;
                slot = digit - hook_back[2:0];
            end
        end else if (frame == effect_pkg::frame_blink_off) begin
            kind = effect_pkg::kind_blank;
        end else if (frame <= effect_pkg::frame_blink_last) begin
            kind = effect_pkg::kind_text;
        end else if (frame <= effect_pkg::frame_erase_last) begin
            if (pos < dash_pos) begin
                kind = effect_pkg::kind_text;
            end else if (pos == dash_pos) begin
                kind = effect_pkg::kind_dash;
            end else begin
                kind = effect_pkg::kind_floor;
            end
        end
    end

endmodule

// File: design/text_store.sv
/*
    text store holding seven character code registers from the write port.
    returns the glyph of one requested slot and blank for codes above 15.
*/

`timescale 1ns/1ps

module text_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  effect_pkg::digit_t  wr_slot,
    input  effect_pkg::code_t   wr_code,
    input  effect_pkg::digit_t  slot,
    output effect_pkg::seg_t    glyph
);

    effect_pkg::code_t codes [effect_pkg::num_digits];
    effect_pkg::code_t rd_code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < effect_pkg::num_digits; i++) begin
                codes[i] <= '0;
            end
        end else if (wr_en && (wr_slot < effect_pkg::num_digits)) begin
            codes[wr_slot] <= wr_code;
        end
    end

    // slot 7 has no register behind it.
    assign rd_code = (slot < effect_pkg::num_digits) ? codes[slot] : 7'd127;

    always_comb begin
        if (rd_code < 7'd16) begin
            glyph = effect_pkg::glyph_table[rd_code[3:0]];
        end else begin
            glyph = effect_pkg::seg_blank;
        end
    end

endmodule

// File: list.f
design/effect_pkg.sv
design/anim_ctrl.sv
design/text_store.sv
design/frame_composer.sv
design/display_driver.sv
design/effect_top.sv
tb/tb_effect_top.sv

// File: tb/tb_effect_top.sv
/*
    testbench for the seven-digit animation display.
    a cycle model of the scan and frame timers predicts every output word.
*/

`timescale 1ns/1ps

module tb_effect_top;

    localparam int tick_div = 4;
    localparam int timeout_cycles = 20000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               run;
    effect_pkg::rate_t  rate;
    logic               wr_en;
    effect_pkg::digit_t wr_slot;
    effect_pkg::code_t  wr_code;
    logic [6:0]         digit_sel;
    effect_pkg::seg_t   segments;

    int    seed;
    int    errors = 0;
    int    checks = 0;
    string test_name = "reset";

    // model state is updated on every rising edge.
    int               m_presc;
    int               m_digit;
    int               m_tick_cnt;
    int               m_frame;
    logic             m_tick;
    int               m_codes [7];
    logic [6:0]       exp_sel = 7'h7f;
    effect_pkg::seg_t exp_seg = effect_pkg::seg_blank;
    int               prev_pos;

    effect_top #(.tick_div(tick_div)) effect_top_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .rate(rate), .wr_en(wr_en),
        .wr_slot(wr_slot), .wr_code(wr_code), .digit_sel(digit_sel), .segments(segments)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic effect_pkg::seg_t text_glyph(input int k);
        if (m_codes[k] < 16) return effect_pkg::glyph_table[m_codes[k]];
        return effect_pkg::seg_blank;
    endfunction

    // frame rule with position p counted from the left.
    function automatic effect_pkg::seg_t expected_seg(input int f, input int p);
        int h;
        if (f == 0 || f == 33) return effect_pkg::seg_floor;
        if (f <= 7) begin
            if (p < 7 - f) return effect_pkg::seg_floor;
            return (p == 7 - f) ? effect_pkg::seg_ball : effect_pkg::seg_blank;
        end
        if (f == 8) return (p == 0) ? text_glyph(0) : effect_pkg::seg_blank;
        if (p == 0 && f <= 21) return text_glyph(0);
        if (f == 15) return effect_pkg::seg_dash;
        if (f <= 21) begin
            h = (f <= 14) ? f - 8 : 22 - f;
            if (p < h) return effect_pkg::seg_dash;
            if (p == h) return effect_pkg::seg_hook;
            return (f <= 14) ? effect_pkg::seg_blank : text_glyph(p - h);
        end
        if (f == 23) return effect_pkg::seg_blank;
        if (f <= 25 || p < 32 - f) return text_glyph(p);
        return (p == 32 - f) ? effect_pkg::seg_dash : effect_pkg::seg_floor;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // returns the scan ticks seen until the model frame reaches target.
    task automatic wait_for_frame(input int target, output int ticks);
        int cycles;
        ticks = 0;
        cycles = 0;
        while (m_frame != target) begin
            @(posedge clk);
            #1;
            if (m_tick) ticks++;
            cycles++;
            if (cycles >= timeout_cycles) begin
                errors++;
                $display("timeout in %s while waiting for frame %0d", test_name, target);
                finish_run();
            end
        end
    endtask

    task automatic write_code(input int slot, input int code);
        wr_en = 1'b1;
        wr_slot = slot[2:0];
        wr_code = code[6:0];
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_presc = 0;
            m_digit = 0;
            m_tick_cnt = 0;
            m_frame = 0;
            m_tick = 1'b0;
            for (int i = 0; i < 7; i++) m_codes[i] = 0;
            exp_sel = 7'h7f;
            exp_seg = effect_pkg::seg_blank;
        end else begin
            // outputs register what the previous state composes.
            exp_sel = ~(7'd1 << (6 - m_digit));
            exp_seg = expected_seg(m_frame, m_digit);
            m_tick = (m_presc == tick_div - 1);
            m_presc = m_tick ? 0 : m_presc + 1;
            if (m_tick) m_digit = (m_digit + 1) % 7;
            if (!run) begin
                m_tick_cnt = 0;
                m_frame = 0;
            end else if (m_tick) begin
                m_tick_cnt++;
                if (m_tick_cnt == effect_pkg::frame_ticks[rate]) begin
                    m_tick_cnt = 0;
                    m_frame = (m_frame == 33) ? 0 : m_frame + 1;
                end
            end
            if (wr_en && wr_slot < 7) m_codes[wr_slot] = wr_code;
        end
    end

    always @(negedge clk) begin
        int pos;
        check_value("digit_sel", exp_sel, digit_sel);
        check_value("segments", exp_seg, segments);
        pos = -1;
        for (int b = 0; b < 7; b++) if (!digit_sel[b]) pos = 6 - b;
        if (!rst_n) begin
            prev_pos = 6;
        end else if (pos >= 0) begin
            if (pos != prev_pos && pos != (prev_pos + 1) % 7) begin
                errors++;
                $display("scan order broken in %s: %0d after %0d", test_name, pos, prev_pos);
            end
            prev_pos = pos;
        end
    end

    initial begin
        int ticks;
        int code;
        seed = 32'h9120;
        rst_n = 1'b0;
        run = 1'b0;
        rate = 2'd0;
        wr_en = 1'b0;
        wr_slot = '0;
        wr_code = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(3);
        check_value("idle floor", effect_pkg::seg_floor, segments);
        wait_cycles(tick_div * 7 * 3);

        test_name = "text load";
        for (int i = 0; i < 24; i++) begin
            code = ($random(seed) & 1) ? ($random(seed) & 15) : ($random(seed) & 127);
            write_code($random(seed) & 7, code);
        end
        write_code(7, 3);
        wait_cycles(2);
        test_name = "full animation";
        rate = 2'd3;
        run = 1'b1;
        wait_for_frame(33, ticks);
        test_name = "wrap";
        wait_for_frame(1, ticks);
        check_value("ticks from frame 33 to 1", 14, ticks);

        test_name = "rates";
        for (int r = 0; r < 4; r++) begin
            run = 1'b0;
            wait_cycles(2);
            rate = r[1:0];
            run = 1'b1;
            wait_for_frame(1, ticks);
            check_value("first frame period", 7 * (8 >> r), ticks);
            wait_for_frame(2, ticks);
            check_value("frame period", 7 * (8 >> r), ticks);
        end

        test_name = "run drop";
        run = 1'b0;
        wait_cycles(2);
        rate = 2'd3;
        run = 1'b1;
        wait_for_frame(12, ticks);
        run = 1'b0;
        wait_cycles(2);
        check_value("floor after drop", effect_pkg::seg_floor, segments);
        wait_cycles(tick_div * 7 * 2);
        test_name = "restart";
        run = 1'b1;
        wait_for_frame(1, ticks);
        check_value("restart period", 7, ticks);
        wait_for_frame(8, ticks);
        run = 1'b0;
        wait_cycles(4);
        finish_run();
    end

endmodule
